// File: Bender.yml
package:
  name: riscv_core

sources:
  - files:
      - hw/core_pkg.sv
      - hw/fetch_unit.sv
      - hw/decoder.sv
      - hw/reg_file.sv
      - hw/alu.sv
      - hw/lsu.sv
      - hw/mem_arbiter.sv
      - hw/riscv_core.sv
  - target: test
    files:
      - verif/tb_riscv_core.sv

// File: hw/alu.sv
/*
 * ALU with add, sub, logic ops, signed compare and operand pass-through
 */
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  wire core_pkg::alu_op_e            i_op,
  input  wire logic [core_pkg::DataWidth-1:0] i_a,
  input  wire logic [core_pkg::DataWidth-1:0] i_b,
  output logic      [core_pkg::DataWidth-1:0] o_res,
  output logic                                o_eq
);

  logic slt;

  assign slt  = $signed(i_a) < $signed(i_b);
  assign o_eq = (i_a == i_b);  // Branch compare for BEQ and BNE

  always_comb begin
    case (i_op)
      core_pkg::ALU_ADD:    o_res = i_a + i_b;
      core_pkg::ALU_SUB:    o_res = i_a - i_b;
      core_pkg::ALU_AND:    o_res = i_a & i_b;
      core_pkg::ALU_OR:     o_res = i_a | i_b;
      core_pkg::ALU_XOR:    o_res = i_a ^ i_b;
      core_pkg::ALU_SLT:    o_res = {{(core_pkg::DataWidth-1){1'b0}}, slt};
      core_pkg::ALU_PASS_B: o_res = i_b;
      default:              o_res = '0;
    endcase
  end

endmodule : alu

`default_nettype wire

// File: hw/core_pkg.sv
/*
 * Shared widths, opcode/ALU/LSU/state enums and instruction field encodings
 */
`default_nettype none

package core_pkg;

  localparam int DataWidth    = 32;
  localparam int RegAddrWidth = 5;

  // RV32I major opcodes handled by this core
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B  // LUI result
  } alu_op_e;

  typedef enum logic [1:0] {
    LSU_NONE,
    LSU_LOAD,
    LSU_STORE
  } lsu_op_e;

  typedef enum logic [1:0] {
    ST_FETCH,
    ST_EXECUTE,
    ST_MEMORY,
    ST_WRITEBACK
  } ctrl_state_e;

  // funct3 / funct7 field values
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_WORD    = 3'b010;  // LW / SW
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;
  localparam logic [6:0] F7_ZERO    = 7'b0000000;
  localparam logic [6:0] F7_SUB     = 7'b0100000;

endpackage : core_pkg

`default_nettype wire

// File: hw/decoder.sv
/*
 * Instruction decoder for the supported RV32I subset
 */
`timescale 1ns/1ns
`default_nettype none

module decoder (
  input  wire logic [   core_pkg::DataWidth-1:0] i_instr,
  output logic      [core_pkg::RegAddrWidth-1:0] o_rs1_addr,
  output logic      [core_pkg::RegAddrWidth-1:0] o_rs2_addr,
  output logic      [core_pkg::RegAddrWidth-1:0] o_rd_addr,
  output logic                                   o_rd_en,
  output logic      [   core_pkg::DataWidth-1:0] o_imm,
  output logic                                   o_use_imm,
  output core_pkg::alu_op_e                      o_alu_op,
  output core_pkg::lsu_op_e                      o_lsu_op,
  output logic                                   o_branch,
  output logic                                   o_branch_ne,
  output logic                                   o_illegal
);

  core_pkg::opcode_e              opcode;
  logic [2:0]                     funct3;
  logic [6:0]                     funct7;
  logic [core_pkg::DataWidth-1:0] imm_i, imm_s, imm_b, imm_u;

  assign opcode = core_pkg::opcode_e'(i_instr[6:0]);
  assign funct3 = i_instr[14:12];
  assign funct7 = i_instr[31:25];

  assign o_rd_addr  = i_instr[11:7];
  assign o_rs1_addr = i_instr[19:15];
  assign o_rs2_addr = i_instr[24:20];

  // Immediates by format, all sign extended from bit 31
  assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
  assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
  assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                  i_instr[11:8], 1'b0};
  assign imm_u = {i_instr[31:12], 12'b0};

  always_comb begin
    o_rd_en     = 1'b0;
    o_use_imm   = 1'b0;
    o_imm       = '0;
    o_alu_op    = core_pkg::ALU_ADD;
    o_lsu_op    = core_pkg::LSU_NONE;
    o_branch    = 1'b0;
    o_branch_ne = 1'b0;
    o_illegal   = 1'b0;

    case (opcode)
      core_pkg::OPC_OP: begin
        o_rd_en = 1'b1;
        case (funct3)
          core_pkg::F3_ADD_SUB: begin
            o_alu_op = (funct7 == core_pkg::F7_SUB) ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
          end
          core_pkg::F3_SLT: o_alu_op = core_pkg::ALU_SLT;
          core_pkg::F3_XOR: o_alu_op = core_pkg::ALU_XOR;
          core_pkg::F3_OR:  o_alu_op = core_pkg::ALU_OR;
          core_pkg::F3_AND: o_alu_op = core_pkg::ALU_AND;
          default:          o_illegal = 1'b1;
        endcase
        // Only SUB may carry a nonzero funct7
        if (funct7 != core_pkg::F7_ZERO &&
            !(funct3 == core_pkg::F3_ADD_SUB && funct7 == core_pkg::F7_SUB)) begin
          o_illegal = 1'b1;
        end
      end
      core_pkg::OPC_OP_IMM: begin
        o_rd_en   = 1'b1;
        o_use_imm = 1'b1;
        o_imm     = imm_i;
        case (funct3)
          core_pkg::F3_ADD_SUB: o_alu_op = core_pkg::ALU_ADD;
          core_pkg::F3_XOR:     o_alu_op = core_pkg::ALU_XOR;
          core_pkg::F3_OR:      o_alu_op = core_pkg::ALU_OR;
          core_pkg::F3_AND:     o_alu_op = core_pkg::ALU_AND;
          default:              o_illegal = 1'b1;  // No SLTI or shifts
        endcase
      end
      core_pkg::OPC_LUI: begin
        o_rd_en   = 1'b1;
        o_use_imm = 1'b1;
        o_imm     = imm_u;
        o_alu_op  = core_pkg::ALU_PASS_B;
      end
      core_pkg::OPC_LOAD: begin
        o_rd_en   = 1'b1;
        o_use_imm = 1'b1;
        o_imm     = imm_i;
        o_lsu_op  = core_pkg::LSU_LOAD;
        o_illegal = (funct3 != core_pkg::F3_WORD);
      end
      core_pkg::OPC_STORE: begin
        o_use_imm = 1'b1;
        o_imm     = imm_s;
        o_lsu_op  = core_pkg::LSU_STORE;
        o_illegal = (funct3 != core_pkg::F3_WORD);
      end
      core_pkg::OPC_BRANCH: begin
        o_imm       = imm_b;   // PC relative, added in the top
        o_branch    = 1'b1;
        o_branch_ne = (funct3 == core_pkg::F3_BNE);
        o_illegal   = (funct3 != core_pkg::F3_BEQ) && (funct3 != core_pkg::F3_BNE);
      end
      default: o_illegal = 1'b1;
    endcase

    // An illegal word has no side effects
    if (o_illegal) begin
      o_rd_en  = 1'b0;
      o_lsu_op = core_pkg::LSU_NONE;
      o_branch = 1'b0;
    end
  end

endmodule : decoder

`default_nettype wire

// File: hw/fetch_unit.sv
/*
 * Program counter and instruction fetch requester
 */
`timescale 1ns/1ns
`default_nettype none

module fetch_unit #(
  parameter logic [core_pkg::DataWidth-1:0] RESET_PC = '0
) (
  input  wire logic                           clk,
  input  wire logic                           rst_n,
  input  wire logic                           i_start,
  input  wire logic                           i_branch_taken,
  input  wire logic [core_pkg::DataWidth-1:0] i_branch_target,
  input  wire logic                           i_advance,
  input  wire logic                           i_done,
  input  wire logic [core_pkg::DataWidth-1:0] i_rdata,
  output logic                                o_req,
  output logic      [core_pkg::DataWidth-1:0] o_addr,
  output logic      [core_pkg::DataWidth-1:0] o_instr,
  output logic      [core_pkg::DataWidth-1:0] o_pc
);

  logic [core_pkg::DataWidth-1:0] pc_q;
  logic [core_pkg::DataWidth-1:0] instr_q;
  logic                           req_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q  <= RESET_PC;
      req_q <= 1'b0;
    end else begin
      if (i_done) req_q <= 1'b0;
      else if (i_start) req_q <= 1'b1;

      if (i_advance) begin
        pc_q <= i_branch_taken ? i_branch_target : pc_q + core_pkg::DataWidth'(4);
      end
    end
  end

  // Instruction holding register
  always_ff @(posedge clk) begin
    if (i_done) instr_q <= i_rdata;
  end

  assign o_req   = req_q;
  assign o_addr  = pc_q;
  assign o_pc    = pc_q;
  assign o_instr = instr_q;

  // Fetch address must not move while the memory stalls
  a_addr_stable : assert property (@(posedge clk) disable iff (!rst_n)
    o_req && !i_done |=> $stable(o_addr));

endmodule : fetch_unit

`default_nettype wire

// File: hw/lsu.sv
/*
 * Load/store requester on the shared memory port, with load data capture
 */
`timescale 1ns/1ns
`default_nettype none

module lsu (
  input  wire logic                           clk,
  input  wire logic                           rst_n,
  input  wire logic                           i_start,
  input  wire core_pkg::lsu_op_e              i_op,
  input  wire logic [core_pkg::DataWidth-1:0] i_addr,
  input  wire logic [core_pkg::DataWidth-1:0] i_wdata,
  input  wire logic                           i_done,
  input  wire logic [core_pkg::DataWidth-1:0] i_rdata,
  output logic                                o_req,
  output logic      [core_pkg::DataWidth-1:0] o_addr,
  output logic      [core_pkg::DataWidth-1:0] o_wdata,
  output logic                                o_we,
  output logic      [core_pkg::DataWidth-1:0] o_load_data,
  output logic                                o_busy
);

  core_pkg::lsu_op_e              op_q;
  logic                           req_q;
  logic [core_pkg::DataWidth-1:0] addr_q;
  logic [core_pkg::DataWidth-1:0] wdata_q;
  logic [core_pkg::DataWidth-1:0] load_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op_q  <= core_pkg::LSU_NONE;
      req_q <= 1'b0;
    end else if (i_done) begin
      req_q <= 1'b0;
    end else if (i_start && i_op != core_pkg::LSU_NONE) begin
      op_q  <= i_op;
      req_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (i_start) begin
      addr_q  <= i_addr;
      wdata_q <= i_wdata;
    end
    if (i_done && op_q == core_pkg::LSU_LOAD) load_q <= i_rdata;
  end

  assign o_req       = req_q;
  assign o_addr      = addr_q;
  assign o_wdata     = wdata_q;
  assign o_we        = (op_q == core_pkg::LSU_STORE);
  assign o_load_data = load_q;
  assign o_busy      = req_q || i_start;  // Busy from the start request on

endmodule : lsu

`default_nettype wire

// File: hw/mem_arbiter.sv
/*
 * Fixed-priority arbiter that hands the shared memory port to the LSU before fetch
 */
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter (
  input  wire logic                           clk,
  input  wire logic                           rst_n,
  input  wire logic                           i_fetch_req,
  input  wire logic [core_pkg::DataWidth-1:0] i_fetch_addr,
  input  wire logic                           i_lsu_req,
  input  wire logic [core_pkg::DataWidth-1:0] i_lsu_addr,
  input  wire logic [core_pkg::DataWidth-1:0] i_lsu_wdata,
  input  wire logic                           i_lsu_we,
  input  wire logic                           i_mem_ready,
  input  wire logic [core_pkg::DataWidth-1:0] i_mem_data,
  output logic                                o_fetch_done,
  output logic                                o_lsu_done,
  output logic      [core_pkg::DataWidth-1:0] o_rdata,
  output logic      [core_pkg::DataWidth-1:0] o_mem_addr,
  output logic      [core_pkg::DataWidth-1:0] o_mem_data,
  output logic      [                  3:0]   o_mem_wr_en,
  output logic                                o_mem_rd_en,
  output logic                                o_mem_valid
);

  logic lock_q;   // Transfer stalled on ready
  logic owner_q;  // 1 when the LSU holds the lock
  logic sel_lsu;
  logic write;
  logic xfer;

  assign sel_lsu = lock_q ? owner_q : i_lsu_req;
  assign o_mem_valid = sel_lsu ? i_lsu_req : i_fetch_req;
  assign xfer = o_mem_valid && i_mem_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lock_q  <= 1'b0;
      owner_q <= 1'b0;
    end else if (o_mem_valid && !i_mem_ready) begin
      lock_q  <= 1'b1;
      owner_q <= sel_lsu;
    end else if (xfer) begin
      lock_q  <= 1'b0;
    end
  end

  assign write       = o_mem_valid && sel_lsu && i_lsu_we;
  assign o_mem_addr  = sel_lsu ? i_lsu_addr : i_fetch_addr;
  assign o_mem_data  = i_lsu_wdata;
  assign o_mem_wr_en = write ? 4'hF : 4'h0;  // Word stores only
  assign o_mem_rd_en = o_mem_valid && !write;

  assign o_fetch_done = xfer && !sel_lsu;
  assign o_lsu_done   = xfer && sel_lsu;
  assign o_rdata      = i_mem_data;

  // A stalled transfer keeps its request steady on the port until ready
  a_hold_stall : assert property (@(posedge clk) disable iff (!rst_n)
    o_mem_valid && !i_mem_ready |=> o_mem_valid && $stable(o_mem_addr) &&
    $stable(o_mem_data) && $stable(o_mem_wr_en));

endmodule : mem_arbiter

`default_nettype wire

// File: hw/reg_file.sv
/*
 * 32 x DATA_WIDTH register file, 2 read ports, 1 write port, x0 fixed at zero
 */
`timescale 1ns/1ns
`default_nettype none

module reg_file #(
  parameter int DATA_WIDTH = 32
) (
  input  wire logic                              clk,
  input  wire logic                              rst_n,
  input  wire logic [core_pkg::RegAddrWidth-1:0] i_rs1_addr,
  input  wire logic [core_pkg::RegAddrWidth-1:0] i_rs2_addr,
  input  wire logic [core_pkg::RegAddrWidth-1:0] i_rd_addr,
  input  wire logic [          DATA_WIDTH-1:0]   i_rd_data,
  input  wire logic                              i_wr_en,
  output logic      [          DATA_WIDTH-1:0]   o_rs1_data,
  output logic      [          DATA_WIDTH-1:0]   o_rs2_data
);

  logic [DATA_WIDTH-1:0] regs [2**core_pkg::RegAddrWidth];

  // Synchronous write port that never touches x0
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regs[0] <= '0;
    end else if (i_wr_en && i_rd_addr != '0) begin
      regs[i_rd_addr] <= i_rd_data;
    end
  end

  assign o_rs1_data = regs[i_rs1_addr];  // Async read
  assign o_rs2_data = regs[i_rs2_addr];

  // Writeback lasts a single cycle per instruction
  a_wr_pulse : assert property (@(posedge clk) disable iff (!rst_n)
    i_wr_en |=> !i_wr_en);

endmodule : reg_file

`default_nettype wire

// File: hw/riscv_core.sv
/*
 * Sequential RV32I subset core, FSM for instruction sequencing
 * Fetch, decode, register file, ALU, LSU and memory arbiter
 */
`timescale 1ns/1ns
`default_nettype none

module riscv_core #(
  parameter logic [core_pkg::DataWidth-1:0] RESET_PC = '0
) (
  input  wire logic                           clk,
  input  wire logic                           rst_n,
  output logic      [core_pkg::DataWidth-1:0] o_mem_addr,
  output logic      [core_pkg::DataWidth-1:0] o_mem_data,
  output logic      [                  3:0]   o_mem_wr_en,
  output logic                                o_mem_rd_en,
  output logic                                o_mem_valid,
  input  wire logic [core_pkg::DataWidth-1:0] i_mem_data,
  input  wire logic                           i_mem_ready,
  output logic                                o_illegal
);

  localparam int DW = core_pkg::DataWidth;
  localparam int AW = core_pkg::RegAddrWidth;

  core_pkg::ctrl_state_e state_q, state_d;

  logic          fetch_req, fetch_done, fetch_start;
  logic [DW-1:0] fetch_addr, instr, pc;
  logic          exec_done, branch_taken;
  logic [DW-1:0] branch_target;

  logic [AW-1:0] rs1_addr, rs2_addr, rd_addr;
  logic          rd_en, use_imm, branch, branch_ne, dec_illegal;
  logic [DW-1:0] imm;
  core_pkg::alu_op_e alu_op;
  core_pkg::lsu_op_e lsu_op;

  logic [DW-1:0] rs1_data, rs2_data, alu_b, alu_res, wb_data;
  logic          alu_eq, reg_we;

  logic          lsu_start, lsu_req, lsu_we, lsu_done, lsu_busy;
  logic [DW-1:0] lsu_addr, lsu_wdata, load_data, mem_rdata;

  // Sequencing FSM
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) state_q <= core_pkg::ST_FETCH;
    else        state_q <= state_d;
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      core_pkg::ST_FETCH:     if (fetch_done) state_d = core_pkg::ST_EXECUTE;
      core_pkg::ST_EXECUTE: begin
        state_d = (lsu_op != core_pkg::LSU_NONE) ? core_pkg::ST_MEMORY : core_pkg::ST_WRITEBACK;
      end
      core_pkg::ST_MEMORY:    if (lsu_done) state_d = core_pkg::ST_WRITEBACK;
      core_pkg::ST_WRITEBACK: state_d = core_pkg::ST_FETCH;
      default:                state_d = core_pkg::ST_FETCH;
    endcase
  end

  assign fetch_start = (state_q == core_pkg::ST_FETCH) && !fetch_req;
  assign exec_done   = (state_q == core_pkg::ST_EXECUTE);
  assign lsu_start   = exec_done && (lsu_op != core_pkg::LSU_NONE);
  assign reg_we      = (state_q == core_pkg::ST_WRITEBACK) && rd_en;
  assign o_illegal   = exec_done && dec_illegal;  // Skipped, PC still advances

  // Operand and writeback selection
  assign alu_b         = use_imm ? imm : rs2_data;
  assign wb_data       = (lsu_op == core_pkg::LSU_LOAD) ? load_data : alu_res;
  assign branch_taken  = branch && (alu_eq ^ branch_ne);
  assign branch_target = pc + imm;

  fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_start         (fetch_start),
    .i_branch_taken  (branch_taken),
    .i_branch_target (branch_target),
    .i_advance       (exec_done),
    .i_done          (fetch_done),
    .i_rdata         (mem_rdata),
    .o_req           (fetch_req),
    .o_addr          (fetch_addr),
    .o_instr         (instr),
    .o_pc            (pc)
  );

  decoder u_decoder (
    .i_instr     (instr),
    .o_rs1_addr  (rs1_addr),
    .o_rs2_addr  (rs2_addr),
    .o_rd_addr   (rd_addr),
    .o_rd_en     (rd_en),
    .o_imm       (imm),
    .o_use_imm   (use_imm),
    .o_alu_op    (alu_op),
    .o_lsu_op    (lsu_op),
    .o_branch    (branch),
    .o_branch_ne (branch_ne),
    .o_illegal   (dec_illegal)
  );

  reg_file #(.DATA_WIDTH(DW)) u_reg_file (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_rs1_addr (rs1_addr),
    .i_rs2_addr (rs2_addr),
    .i_rd_addr  (rd_addr),
    .i_rd_data  (wb_data),
    .i_wr_en    (reg_we),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  alu u_alu (
    .i_op  (alu_op),
    .i_a   (rs1_data),
    .i_b   (alu_b),
    .o_res (alu_res),
    .o_eq  (alu_eq)
  );

  lsu u_lsu (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_start     (lsu_start),
    .i_op        (lsu_op),
    .i_addr      (alu_res),   // rs1 + offset
    .i_wdata     (rs2_data),
    .i_done      (lsu_done),
    .i_rdata     (mem_rdata),
    .o_req       (lsu_req),
    .o_addr      (lsu_addr),
    .o_wdata     (lsu_wdata),
    .o_we        (lsu_we),
    .o_load_data (load_data),
    .o_busy      (lsu_busy)
  );

  mem_arbiter u_arbiter (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_fetch_req  (fetch_req),
    .i_fetch_addr (fetch_addr),
    .i_lsu_req    (lsu_req),
    .i_lsu_addr   (lsu_addr),
    .i_lsu_wdata  (lsu_wdata),
    .i_lsu_we     (lsu_we),
    .i_mem_ready  (i_mem_ready),
    .i_mem_data   (i_mem_data),
    .o_fetch_done (fetch_done),
    .o_lsu_done   (lsu_done),
    .o_rdata      (mem_rdata),
    .o_mem_addr   (o_mem_addr),
    .o_mem_data   (o_mem_data),
    .o_mem_wr_en  (o_mem_wr_en),
    .o_mem_rd_en  (o_mem_rd_en),
    .o_mem_valid  (o_mem_valid)
  );

  // MEMORY is entered only for LW/SW, and the LSU then owns a request
  a_mem_state : assert property (@(posedge clk) disable iff (!rst_n)
    state_q == core_pkg::ST_MEMORY |-> lsu_op != core_pkg::LSU_NONE && lsu_busy);

endmodule : riscv_core

`default_nettype wire

// File: verif/tb_riscv_core.sv
/*
 * Testbench for riscv_core with a memory model that has random ready delay,
 * a preloaded program and concurrent assertions on every memory transfer
 */
`timescale 1ns/1ns
`default_nettype none

module tb_riscv_core;

  localparam logic [31:0] RESET_PC   = 32'h0;
  localparam logic [31:0] MarkerAddr = 32'h1F0;  // Written only if a branch misbehaves
  localparam int          NumTests   = 6;
  localparam int          MemWords   = 1024;
  localparam logic [6:0]  OpReg      = 7'h33;
  localparam logic [6:0]  OpImm      = 7'h13;
  localparam logic [6:0]  OpLui      = 7'h37;
  localparam logic [6:0]  OpLoad     = 7'h03;
  localparam logic [6:0]  OpStore    = 7'h23;
  localparam logic [6:0]  OpBranch   = 7'h63;

  logic        clk;
  logic        rst_n;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_wr_en;
  logic        mem_rd_en;
  logic        mem_valid;
  logic [31:0] mem_rdata;
  logic        mem_ready;
  logic        illegal;
  logic        write_acc;

  logic [31:0] mem_words [MemWords];
  logic [31:0] ref_x [32];        // Register values by RV32I rules
  logic [31:0] exp_addr [32];
  logic [31:0] exp_data [32];
  int          exp_test [32];
  int          test_err [NumTests];
  string       test_name [NumTests];
  int          n_exp;
  int          n_instr;
  int          store_idx;
  int          shown_idx;
  int          illegal_count;
  int          err_count;
  int          wait_left;
  int          cycles;
  int          cycle_limit;
  logic        first_xfer_seen;
  logic        reset_shown;
  integer      seed = 39733;

  riscv_core #(.RESET_PC(RESET_PC)) u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .o_mem_addr  (mem_addr),
    .o_mem_data  (mem_wdata),
    .o_mem_wr_en (mem_wr_en),
    .o_mem_rd_en (mem_rd_en),
    .o_mem_valid (mem_valid),
    .i_mem_data  (mem_rdata),
    .i_mem_ready (mem_ready),
    .o_illegal   (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OpReg};
  endfunction

  function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] sw_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OpStore};
  endfunction

  function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OpBranch};
  endfunction

  task automatic emit(input logic [31:0] word);
    mem_words[n_instr] = word;  // Program starts at address 0
    n_instr++;
  endtask

  // SW rs2, offset(x0) plus its entry in the expected store list
  task automatic store_word(input int test, input logic [4:0] rs2, input logic [11:0] offset);
    emit(sw_word(rs2, 5'd0, offset));
    exp_addr[n_exp] = {20'h0, offset};
    exp_data[n_exp] = ref_x[rs2];
    exp_test[n_exp] = test;
    n_exp++;
  endtask

  task automatic report_value(input int test, input string sig, input logic [31:0] exp,
                              input logic [31:0] act);
    $display("** Error at %0t ns: %s expected 0x%08h, got 0x%08h", $time, sig, exp, act);
    err_count++;
    test_err[test]++;
  endtask

  task automatic report_event(input int test, input string what);
    $display("Error at %0t ns: %s", $time, what);
    err_count++;
    test_err[test]++;
  endtask

  task automatic show_result(input int test);
    $display("[%0t ns] test %0d %s: %s", $time, test, test_name[test],
             (test_err[test] == 0) ? "passed" : "failed");
  endtask

  task automatic load_program();
    for (int i = 0; i < MemWords; i++) begin
      mem_words[i] = 32'hA5A5_0000 ^ (32'(i) << 2);
    end
    mem_words[32'h200 >> 2] = 32'h1357_9BDF;
    mem_words[32'h204 >> 2] = 32'h8642_0ACE;
    foreach (ref_x[r]) ref_x[r] = '0;

    // LUI and register-immediate ops
    emit({20'h12345, 5'd1, OpLui});
    emit(i_type(OpImm, 3'b000, 5'd1, 5'd1, 12'h678));  // ADDI
    emit(i_type(OpImm, 3'b000, 5'd2, 5'd0, 12'hFFB));  // ADDI -5
    emit(i_type(OpImm, 3'b100, 5'd3, 5'd1, 12'h0FF));  // XORI
    emit(i_type(OpImm, 3'b111, 5'd4, 5'd1, 12'h0F0));  // ANDI
    emit(i_type(OpImm, 3'b110, 5'd5, 5'd1, 12'h80F));  // ORI with negative imm
    ref_x[1] = {20'h12345, 12'h000} + sext12(12'h678);
    ref_x[2] = sext12(12'hFFB);
    ref_x[3] = ref_x[1] ^ sext12(12'h0FF);
    ref_x[4] = ref_x[1] & sext12(12'h0F0);
    ref_x[5] = ref_x[1] | sext12(12'h80F);
    for (int r = 1; r <= 5; r++) begin
      store_word(1, 5'(r), 12'h100 + 12'(4 * (r - 1)));
    end

    // Register-register ops with a negative operand
    emit(i_type(OpImm, 3'b000, 5'd6, 5'd0, 12'd100));
    emit(i_type(OpImm, 3'b000, 5'd7, 5'd0, 12'hFF9));  // -7
    emit(r_type(7'h20, 3'b000, 5'd8, 5'd6, 5'd7));     // SUB
    emit(r_type(7'h00, 3'b111, 5'd9, 5'd1, 5'd2));     // AND
    emit(r_type(7'h00, 3'b110, 5'd10, 5'd6, 5'd7));    // OR
    emit(r_type(7'h00, 3'b100, 5'd11, 5'd1, 5'd2));    // XOR
    emit(r_type(7'h00, 3'b010, 5'd12, 5'd7, 5'd6));    // SLT gives 1
    emit(r_type(7'h00, 3'b010, 5'd13, 5'd6, 5'd7));    // SLT gives 0
    emit(r_type(7'h00, 3'b000, 5'd14, 5'd6, 5'd7));    // ADD
    ref_x[6]  = 32'd100;
    ref_x[7]  = sext12(12'hFF9);
    ref_x[8]  = ref_x[6] - ref_x[7];
    ref_x[9]  = ref_x[1] & ref_x[2];
    ref_x[10] = ref_x[6] | ref_x[7];
    ref_x[11] = ref_x[1] ^ ref_x[2];
    ref_x[12] = ($signed(ref_x[7]) < $signed(ref_x[6])) ? 32'd1 : 32'd0;
    ref_x[13] = ($signed(ref_x[6]) < $signed(ref_x[7])) ? 32'd1 : 32'd0;
    ref_x[14] = ref_x[6] + ref_x[7];
    for (int r = 8; r <= 14; r++) begin
      store_word(2, 5'(r), 12'h120 + 12'(4 * (r - 8)));
    end

    // Load, modify, store back
    emit(i_type(OpLoad, 3'b010, 5'd15, 5'd0, 12'h200));
    emit(i_type(OpImm, 3'b000, 5'd15, 5'd15, 12'h321));
    ref_x[15] = mem_words[32'h200 >> 2] + sext12(12'h321);
    store_word(3, 5'd15, 12'h140);
    emit(i_type(OpImm, 3'b000, 5'd16, 5'd0, 12'h200));
    emit(i_type(OpLoad, 3'b010, 5'd17, 5'd16, 12'h004));  // Base register plus offset
    ref_x[16] = 32'h200;
    ref_x[17] = mem_words[32'h204 >> 2];
    store_word(3, 5'd17, 12'h144);

    // Branches around the marker store
    emit(i_type(OpImm, 3'b000, 5'd18, 5'd0, 12'd9));
    emit(i_type(OpImm, 3'b000, 5'd19, 5'd0, 12'd9));
    ref_x[18] = 32'd9;
    ref_x[19] = 32'd9;
    emit(b_type(3'b000, 5'd18, 5'd19, 13'd8));  // BEQ taken
    emit(sw_word(5'd18, 5'd0, MarkerAddr[11:0]));
    store_word(4, 5'd19, 12'h150);
    emit(b_type(3'b001, 5'd18, 5'd19, 13'd8));  // BNE not taken
    store_word(4, 5'd18, 12'h154);
    emit(b_type(3'b001, 5'd18, 5'd0, 13'd8));   // BNE taken
    emit(sw_word(5'd18, 5'd0, MarkerAddr[11:0]));
    store_word(4, 5'd6, 12'h158);

    // Illegal word with rd = x31 must leave x31 alone
    emit(i_type(OpImm, 3'b000, 5'd31, 5'd0, 12'h077));
    ref_x[31] = 32'h77;
    emit(32'hFFFF_FFFF);
    store_word(5, 5'd31, 12'h160);
    emit(b_type(3'b000, 5'd0, 5'd0, 13'd0));  // Park in a self loop

    cycle_limit = n_instr * 12 + 40;  // Worst case 11 cycles per instruction
  endtask

  // Memory write side, store bookkeeping and ready delay draw
  always @(posedge clk) begin
    if (rst_n && mem_valid && mem_ready) begin
      if (mem_wr_en != 4'h0) begin
        mem_words[mem_addr[11:2]] <= mem_wdata;
        if (store_idx < n_exp) store_idx <= store_idx + 1;
      end
      first_xfer_seen <= 1'b1;
      wait_left       <= $random(seed) & 3;
    end
    if (rst_n && illegal) illegal_count <= illegal_count + 1;
  end

  // Ready after 0 to 3 wait cycles and read data from the current address
  always @(negedge clk) begin
    if (!(rst_n && mem_valid)) begin
      mem_ready = 1'b0;
    end else if (wait_left == 0) begin
      mem_ready = 1'b1;
    end else begin
      mem_ready = 1'b0;
      wait_left = wait_left - 1;
    end
    mem_rdata = mem_words[mem_addr[11:2]];
  end

  // One line per test once its last store has gone by
  always @(negedge clk) begin
    if (first_xfer_seen && !reset_shown) begin
      show_result(0);
      reset_shown = 1'b1;
    end
    while (shown_idx < store_idx && shown_idx < n_exp) begin
      if (shown_idx == n_exp - 1 || exp_test[shown_idx + 1] != exp_test[shown_idx]) begin
        show_result(exp_test[shown_idx]);
      end
      shown_idx++;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, %0d of %0d stores seen", cycles, store_idx, n_exp);
      $display("TEST FAILED");
      $finish;
    end
  end

  assign write_acc = rst_n && mem_valid && mem_ready && (mem_wr_en != 4'h0);

  a_store_addr : assert property (@(posedge clk)
    write_acc && store_idx < n_exp |-> mem_addr == exp_addr[store_idx])
    else report_value(exp_test[$sampled(store_idx)], "o_mem_addr",
                      exp_addr[$sampled(store_idx)], $sampled(mem_addr));

  a_store_data : assert property (@(posedge clk)
    write_acc && store_idx < n_exp |-> mem_wdata == exp_data[store_idx])
    else report_value(exp_test[$sampled(store_idx)], "o_mem_data",
                      exp_data[$sampled(store_idx)], $sampled(mem_wdata));

  // Word stores drive all four strobes and no read enable
  a_store_strobe : assert property (@(posedge clk) write_acc |-> mem_wr_en == 4'hF)
    else report_value(3, "o_mem_wr_en", 32'hF, 32'($sampled(mem_wr_en)));

  a_store_rd_en : assert property (@(posedge clk) write_acc |-> !mem_rd_en)
    else report_value(3, "o_mem_rd_en", 32'h0, 32'($sampled(mem_rd_en)));

  // Fetches and loads
  a_read_rd_en : assert property (@(posedge clk)
    rst_n && mem_valid && mem_wr_en == 4'h0 |-> mem_rd_en)
    else report_value(3, "o_mem_rd_en", 32'h1, 32'($sampled(mem_rd_en)));

  a_no_extra : assert property (@(posedge clk) write_acc |-> store_idx < n_exp)
    else report_event(4, "store seen after the last expected one");

  a_no_marker : assert property (@(posedge clk) write_acc |-> mem_addr != MarkerAddr)
    else report_event(4, "store to the marker address, a branch went the wrong way");

  a_reset_valid : assert property (@(posedge clk) !rst_n || $rose(rst_n) |-> !mem_valid)
    else report_value(0, "o_mem_valid", 32'h0, 32'($sampled(mem_valid)));

  a_reset_strobe : assert property (@(posedge clk)
    !rst_n || $rose(rst_n) |-> mem_wr_en == 4'h0)
    else report_value(0, "o_mem_wr_en", 32'h0, 32'($sampled(mem_wr_en)));

  a_first_addr : assert property (@(posedge clk)
    rst_n && mem_valid && mem_ready && !first_xfer_seen |-> mem_addr == RESET_PC)
    else report_value(0, "o_mem_addr", RESET_PC, $sampled(mem_addr));

  a_illegal_once : assert property (@(posedge clk) rst_n && illegal |-> illegal_count == 0)
    else report_event(5, "o_illegal pulsed more than once");

  a_illegal_seen : assert property (@(posedge clk)
    write_acc && store_idx == n_exp - 1 |-> illegal_count == 1)
    else report_event(5, "o_illegal did not pulse exactly once before the last store");

  initial begin
    int passes;
    int fails;
    passes          = 0;
    fails           = 0;
    rst_n           = 1'b0;
    mem_ready       = 1'b0;
    mem_rdata       = '0;
    store_idx       = 0;
    shown_idx       = 0;
    illegal_count   = 0;
    err_count       = 0;
    cycles          = 0;
    first_xfer_seen = 1'b0;
    reset_shown     = 1'b0;
    foreach (test_err[t]) test_err[t] = 0;
    test_name[0] = "reset state";
    test_name[1] = "immediate ops and LUI";
    test_name[2] = "register ALU ops";
    test_name[3] = "load/store round trip";
    test_name[4] = "branches";
    test_name[5] = "illegal encoding";
    load_program();
    wait_left = $random(seed) & 3;

    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    while (store_idx < n_exp) @(negedge clk);
    repeat (30) @(negedge clk);  // Quiet window while the core spins in its self loop

    for (int t = 0; t < NumTests; t++) begin
      if (test_err[t] == 0) passes++;
      else fails++;
    end
    $display("Tests passed: %0d, failed: %0d, errors: %0d", passes, fails, err_count);
    if (err_count == 0 && fails == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : tb_riscv_core

`default_nettype wire

// File: vlog.f
hw/core_pkg.sv
hw/fetch_unit.sv
hw/decoder.sv
hw/reg_file.sv
hw/alu.sv
hw/lsu.sv
hw/mem_arbiter.sv
hw/riscv_core.sv
verif/tb_riscv_core.sv
